// File: build.f
+incdir+src
src/mem_stage_pkg.sv
src/mem_ctrl_if.sv
src/branch_resolve.sv
src/bus_wait_timer.sv
src/mem_bus_fsm.sv
src/load_align.sv
src/mem_wb_reg.sv
src/mem_access_top.sv
verification/tb_mem_access.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    -f build.f \
    --top-module tb_mem_access \
    -o sim_mem_access

./obj_dir/sim_mem_access | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: verification/mem_access_stim.txt
// memb rw dsz wbs rwen wreg pc_branch pc_plus4 alu rs2 instr waits rdata | exp: taken pc mem fault
// all hex; rdata of non-load lines is replaced by random filler
1 0 2 0 1 0a 00001000 00000ff8 00000000 00000000 00000063 00 00000000 1 00001000 00000000 0
1 0 2 0 1 0a 00001000 00000ff8 00000005 00000000 00000063 00 00000000 0 00001000 00000000 0
2 0 2 0 1 0a 00001000 00000ff8 00000005 00000000 00000063 00 00000000 1 00001000 00000000 0
3 0 2 0 1 0a 00001000 00000ff8 00000001 00000000 00000063 00 00000000 0 00001000 00000000 0
4 0 2 0 1 0a 00001000 00000ff8 00000001 00000000 00000063 00 00000000 1 00001000 00000000 0
5 0 2 2 1 01 00001000 00000ff8 00000040 00000000 0000006f 00 00000000 1 00001000 00000000 0
6 0 2 2 1 01 00001000 00000ff8 00002468 00000000 00000067 00 00000000 1 00002468 00000000 0
0 0 2 0 1 0a 00001000 00000ff8 00000000 00000000 00000013 00 00000000 0 00001000 00000000 0
0 2 0 1 1 05 00000000 00000104 00000100 00000000 00000003 00 a1b2c3d4 0 00000000 ffffffd4 0
0 2 0 1 1 05 00000000 00000104 00000101 00000000 00000003 00 a1b2c3d4 0 00000000 ffffffc3 0
0 2 0 1 1 05 00000000 00000104 00000102 00000000 00004003 00 a1b2c3d4 0 00000000 000000b2 0
0 2 0 1 1 05 00000000 00000104 00000103 00000000 00004003 00 a1b2c3d4 0 00000000 000000a1 0
0 2 1 1 1 06 00000000 00000104 00000104 00000000 00001003 00 a1b2c3d4 0 00000000 ffffc3d4 0
0 2 1 1 1 06 00000000 00000104 00000106 00000000 00005003 00 a1b2c3d4 0 00000000 0000a1b2 0
0 2 2 1 1 07 00000000 00000104 00000108 00000000 00002003 00 a1b2c3d4 0 00000000 a1b2c3d4 0
0 2 0 1 1 08 00000000 00000104 00000110 00000000 00000003 03 0000007f 0 00000000 0000007f 0
0 2 2 1 1 09 00000000 00000104 00000114 00000000 00002003 10 12345678 0 00000000 12345678 0
0 2 2 1 1 0b 00000000 00000104 00000118 00000000 00002003 14 87654321 0 00000000 00000000 1
0 1 2 0 0 00 00000000 00000104 00000200 deadbeef 00002023 02 00000000 0 00000000 00000000 0
0 1 0 0 0 00 00000000 00000104 00000203 00000055 00000023 00 00000000 0 00000000 00000000 0

// File: verification/tb_mem_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module tb_mem_access import mem_stage_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int MAX_VEC    = 64;

    logic clk, rst, keep, nop, reg_write_in, dbusy, dready_n;
    memb_e   memb_in;
    memrw_e  memrw_in;
    dsize_e  dsize_in, dsize;
    wb_sel_e wb_sel_in, wb_sel_out;
    logic [`MS_XLEN-1:0]   pc_branch_in, pc_plus4_in, alu_in, rs2_data_in, instr_in, rdata;
    logic [`MS_REG_AW-1:0] wreg_in, wreg_out;
    logic [`MS_XLEN-1:0]   daddr, wdata, branch_pc, alu_out, pc_plus4_out;
    logic [`MS_XLEN-1:0]   mem_data_out, instr_out;
    logic dreq, dwrite, stall, bus_fault, branch_taken, reg_write_out;

    // one entry per stimulus line
    logic [31:0] v_f[MAX_VEC][17];
    int n_vec;
    int errors;
    int n_pass;
    int n_fail;
    integer seed;

    mem_access_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic check_branch(input memb_e kind, input logic exp_taken,
                                input logic [`MS_XLEN-1:0] exp_target);
        if (branch_taken !== exp_taken || branch_pc !== exp_target) begin
            $display("FAILED %0t: branch %s gave taken %b pc %h, expected %b %h", $time,
                     kind.name(), branch_taken, branch_pc, exp_taken, exp_target);
            errors++;
        end
    endtask

    task automatic check_wb(input wb_sel_e exp_sel, input logic [`MS_REG_AW-1:0] exp_reg,
                            input logic [`MS_XLEN-1:0] exp_data);
        if (wb_sel_out !== exp_sel || wreg_out !== exp_reg || mem_data_out !== exp_data) begin
            $display("FAILED %0t: stage 3 gave sel %s reg %h data %h, expected %s %h %h",
                     $time, wb_sel_out.name(), wreg_out, mem_data_out, exp_sel.name(),
                     exp_reg, exp_data);
            errors++;
        end
    endtask

    // fields that stage 3 passes on unchanged
    task automatic check_carried(input logic exp_rw, input logic [`MS_XLEN-1:0] exp_alu,
                                 input logic [`MS_XLEN-1:0] exp_pc4,
                                 input logic [`MS_XLEN-1:0] exp_instr);
        if (reg_write_out !== exp_rw || alu_out !== exp_alu || pc_plus4_out !== exp_pc4
                || instr_out !== exp_instr) begin
            $display("FAILED %0t: carried rw %b alu %h pc4 %h ins %h, expected %b %h %h %h",
                     $time, reg_write_out, alu_out, pc_plus4_out, instr_out, exp_rw,
                     exp_alu, exp_pc4, exp_instr);
            errors++;
        end
    endtask

    task automatic check_fault(input logic exp_fault, input logic seen);
        if (seen !== exp_fault) begin
            $display("FAILED %0t: bus_fault seen %b, expected %b", $time, seen, exp_fault);
            errors++;
        end
    endtask

    task automatic check_bus(input memrw_e op, input logic [`MS_XLEN-1:0] exp_addr,
                             input logic [`MS_XLEN-1:0] exp_wdata, input dsize_e exp_size);
        if (dreq !== 1'b1 || dwrite !== op[0] || daddr !== exp_addr || dsize !== exp_size
                || (op[0] && wdata !== exp_wdata)) begin
            $display("FAILED %0t: bus req %b wr %b addr %h data %h size %s for %s", $time,
                     dreq, dwrite, daddr, wdata, dsize.name(), op.name());
            errors++;
        end
    endtask

    task automatic read_stim();
        int fd;
        string line;
        logic [31:0] t[17];
        fd = $fopen("verification/mem_access_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
            return;
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 10 || line[0] == "/") continue; // comments and blanks
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8], t[9],
                        t[10], t[11], t[12], t[13], t[14], t[15], t[16]) != 17) begin
                $display("malformed stimulus line: %s", line);
                errors++;
                continue;
            end
            v_f[n_vec] = t;
            n_vec++;
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int i);
        int cyc;
        int start_errors;
        int waits;
        logic fault_seen;
        logic finished;
        start_errors = errors;
        cyc = 0;
        waits = int'(v_f[i][11]);
        fault_seen = 1'b0;
        finished = 1'b0;
        memb_in = memb_e'(v_f[i][0][2:0]);
        memrw_in = memrw_e'(v_f[i][1][1:0]);
        dsize_in = dsize_e'(v_f[i][2][1:0]);
        wb_sel_in = wb_sel_e'(v_f[i][3][1:0]);
        reg_write_in = v_f[i][4][0];
        wreg_in = v_f[i][5][`MS_REG_AW-1:0];
        pc_branch_in = v_f[i][6];
        pc_plus4_in = v_f[i][7];
        alu_in = v_f[i][8];
        rs2_data_in = v_f[i][9];
        instr_in = v_f[i][10];
        rdata = (memrw_in == MEMRW_LOAD) ? v_f[i][12] : $random(seed); // filler
        dbusy = (waits != 0);
        dready_n = (waits != 0);
        #20;
        check_branch(memb_in, v_f[i][13][0], v_f[i][14]);
        while (!finished) begin
            if (memrw_in != MEMRW_NONE) check_bus(memrw_in, alu_in, rs2_data_in, dsize_in);
            if (bus_fault) fault_seen = 1'b1;
            if (!stall) begin
                finished = 1'b1;
            end else begin
                if (waits == 0) begin
                    $display("FAILED %0t: stall rose on a zero-wait access", $time);
                    errors++;
                end
                if (cyc > 0 && reg_write_out !== 1'b0) begin
                    $display("FAILED %0t: no bubble in stage 3 during stall", $time);
                    errors++;
                end
                if (cyc > 0) check_wb(WB_ALU, '0, '0);
                @(posedge clk);
                #2;
                cyc++;
                dbusy = (cyc < waits); // bus model
                dready_n = (cyc < waits);
                #20;
            end
        end
        @(posedge clk);
        #2;
        check_wb(wb_sel_in, wreg_in, v_f[i][15]);
        check_carried(v_f[i][4][0], v_f[i][8], v_f[i][7], v_f[i][10]);
        check_fault(v_f[i][16][0], fault_seen);
        dbusy = 1'b0;
        dready_n = 1'b1;
        if (errors == start_errors) begin
            $display("test %0d passed", i);
            n_pass++;
        end else begin
            $display("test %0d failed", i);
            n_fail++;
        end
    endtask

    // keep holds stage 3, nop clears it, keep beats nop
    task automatic hold_and_flush();
        int start_errors;
        logic [`MS_XLEN-1:0]   saved_alu;
        logic [`MS_REG_AW-1:0] saved_reg;
        wb_sel_e               saved_sel;
        start_errors = errors;
        saved_alu = alu_out;
        saved_reg = wreg_out;
        saved_sel = wb_sel_out;
        keep = 1'b1;
        memrw_in = MEMRW_LOAD;
        wreg_in = 5'h1f;
        alu_in = 32'h0000_0300;
        #20;
        if (dreq !== 1'b0 || stall !== 1'b0) begin
            $display("FAILED %0t: keep did not drop dreq", $time);
            errors++;
        end
        @(posedge clk);
        #2;
        nop = 1'b1;
        if (alu_out !== saved_alu) begin
            $display("FAILED %0t: keep did not hold alu_out", $time);
            errors++;
        end
        check_wb(saved_sel, saved_reg, '0);
        @(posedge clk);
        #2;
        if (alu_out !== saved_alu) begin
            $display("FAILED %0t: nop won over keep", $time);
            errors++;
        end
        check_wb(saved_sel, saved_reg, '0);
        keep = 1'b0;
        memrw_in = MEMRW_NONE;
        @(posedge clk);
        #2;
        nop = 1'b0;
        if (alu_out !== '0 || reg_write_out !== 1'b0) begin
            $display("FAILED %0t: nop did not clear stage 3", $time);
            errors++;
        end
        check_wb(WB_ALU, '0, '0);
        if (errors == start_errors) begin
            $display("test keep/nop passed");
            n_pass++;
        end else begin
            $display("test keep/nop failed");
            n_fail++;
        end
    endtask

    initial begin
        int i;
        seed = 85;
        rst = 1'b0;
        keep = 1'b0;
        nop = 1'b0;
        reg_write_in = 1'b0;
        memb_in = MEMB_NONE;
        memrw_in = MEMRW_NONE;
        dsize_in = DSIZE_WORD;
        wb_sel_in = WB_ALU;
        pc_branch_in = '0;
        pc_plus4_in = '0;
        alu_in = '0;
        rs2_data_in = '0;
        wreg_in = '0;
        instr_in = '0;
        dbusy = 1'b0;
        dready_n = 1'b1;
        rdata = '0;
        read_stim();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;
        for (i = 0; i < n_vec; i++) run_vector(i);
        hold_and_flush();
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // each line gets limit + 4 cycles, plus reset and the keep/nop test
    initial begin
        wait (n_vec > 0);
        #((n_vec + 1) * (`MS_WAIT_LIMIT + 4) * CLK_PERIOD + 12 * CLK_PERIOD);
        $display("watchdog: the run timed out before all tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/mem_access_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_access_top import mem_stage_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  keep,
    input  logic                  nop,
    input  logic                  reg_write_in,
    input  memb_e                 memb_in,
    input  memrw_e                memrw_in,
    input  dsize_e                dsize_in,
    input  wb_sel_e               wb_sel_in,
    input  logic [`MS_XLEN-1:0]   pc_branch_in,
    input  logic [`MS_XLEN-1:0]   pc_plus4_in,
    input  logic [`MS_XLEN-1:0]   alu_in,
    input  logic [`MS_XLEN-1:0]   rs2_data_in,
    input  logic [`MS_REG_AW-1:0] wreg_in,
    input  logic [`MS_XLEN-1:0]   instr_in,
    input  logic                  dbusy,
    input  logic                  dready_n,
    input  logic [`MS_XLEN-1:0]   rdata,
    output logic [`MS_XLEN-1:0]   daddr,
    output logic                  dreq,
    output logic                  dwrite,
    output dsize_e                dsize,
    output logic [`MS_XLEN-1:0]   wdata,
    output logic                  stall,
    output logic                  bus_fault,
    output logic [`MS_XLEN-1:0]   branch_pc,
    output logic                  branch_taken,
    output logic                  reg_write_out,
    output wb_sel_e               wb_sel_out,
    output logic [`MS_REG_AW-1:0] wreg_out,
    output logic [`MS_XLEN-1:0]   alu_out,
    output logic [`MS_XLEN-1:0]   pc_plus4_out,
    output logic [`MS_XLEN-1:0]   mem_data_out,
    output logic [`MS_XLEN-1:0]   instr_out
);

    mem_ctrl_if ctrl_if ();

    logic                wait_count_en;
    logic                wait_clear;
    logic                wait_expired;
    logic [`MS_XLEN-1:0] load_value;

    assign daddr     = alu_in;
    assign dsize     = dsize_in;
    assign wdata     = rs2_data_in;
    assign stall     = ctrl_if.stall;
    assign bus_fault = ctrl_if.fault;

    branch_resolve branch_i (
        .memb       (memb_in),
        .alu_result (alu_in),
        .pc_branch  (pc_branch_in),
        .taken      (branch_taken),
        .target     (branch_pc)
    );

    mem_bus_fsm fsm_i (
        .clk, .rst, .keep,
        .memrw         (memrw_in),
        .dbusy, .dready_n,
        .wait_expired  (wait_expired),
        .dreq, .dwrite,
        .wait_count_en (wait_count_en),
        .wait_clear    (wait_clear),
        .ctrl          (ctrl_if.fsm)
    );

    bus_wait_timer timer_i (
        .clk, .rst,
        .count_en (wait_count_en),
        .clear    (wait_clear),
        .expired  (wait_expired)
    );

    load_align align_i (
        .rdata,
        .addr_low      (alu_in[1:0]),
        .dsize         (dsize_in),
        .unsigned_load (instr_in[14]), // funct3 bit 2 marks lbu/lhu
        .ctrl          (ctrl_if.dp),
        .load_value    (load_value)
    );

    mem_wb_reg wb_reg_i (
        .clk, .rst, .keep, .nop,
        .reg_write_in, .wb_sel_in, .wreg_in, .alu_in, .pc_plus4_in, .instr_in,
        .load_value    (load_value),
        .is_load       (memrw_in == MEMRW_LOAD),
        .ctrl          (ctrl_if.dp),
        .reg_write_out, .wb_sel_out, .wreg_out, .alu_out, .pc_plus4_out,
        .mem_data_out, .instr_out
    );

endmodule

`default_nettype wire

// File: src/mem_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_wb_reg import mem_stage_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  keep,
    input  logic                  nop,
    input  logic                  reg_write_in,
    input  wb_sel_e               wb_sel_in,
    input  logic [`MS_REG_AW-1:0] wreg_in,
    input  logic [`MS_XLEN-1:0]   alu_in,
    input  logic [`MS_XLEN-1:0]   pc_plus4_in,
    input  logic [`MS_XLEN-1:0]   instr_in,
    input  logic [`MS_XLEN-1:0]   load_value,
    input  logic                  is_load,
    mem_ctrl_if.dp                ctrl,
    output logic                  reg_write_out,
    output wb_sel_e               wb_sel_out,
    output logic [`MS_REG_AW-1:0] wreg_out,
    output logic [`MS_XLEN-1:0]   alu_out,
    output logic [`MS_XLEN-1:0]   pc_plus4_out,
    output logic [`MS_XLEN-1:0]   mem_data_out,
    output logic [`MS_XLEN-1:0]   instr_out
);

    logic                bubble;
    logic [`MS_XLEN-1:0] mem_data_next;

    assign bubble = nop || ctrl.stall;
    assign mem_data_next = (is_load && (ctrl.capture || ctrl.fault)) ? load_value : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            reg_write_out <= 1'b0;
            wb_sel_out    <= WB_ALU;
            wreg_out      <= '0;
            alu_out       <= '0;
            pc_plus4_out  <= '0;
            mem_data_out  <= '0;
            instr_out     <= '0;
        end else if (keep) begin
            // hold everything
        end else if (bubble) begin
            reg_write_out <= 1'b0;
            wb_sel_out    <= WB_ALU;
            wreg_out      <= '0;
            alu_out       <= '0;
            pc_plus4_out  <= '0;
            mem_data_out  <= '0;
            instr_out     <= '0;
        end else begin
            reg_write_out <= reg_write_in;
            wb_sel_out    <= wb_sel_in;
            wreg_out      <= wreg_in;
            alu_out       <= alu_in;
            pc_plus4_out  <= pc_plus4_in;
            mem_data_out  <= mem_data_next;
            instr_out     <= instr_in;
        end
    end

endmodule

`default_nettype wire

// File: src/load_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module load_align import mem_stage_pkg::*; (
    input  logic [`MS_XLEN-1:0] rdata,
    input  logic [1:0]          addr_low,
    input  dsize_e              dsize,
    input  logic                unsigned_load,
    mem_ctrl_if.dp              ctrl,
    output logic [`MS_XLEN-1:0] load_value
);

    load_word_u          rword;
    logic [7:0]          lane_byte;
    logic [15:0]         lane_half;
    logic [`MS_XLEN-1:0] extended;

    assign rword = load_word_u'(rdata);

    always_comb begin
        lane_byte = rword.lanes[addr_low];
        // upper or lower halfword
        lane_half = addr_low[1] ? {rword.lanes[3], rword.lanes[2]}
                                : {rword.lanes[1], rword.lanes[0]};
        case (dsize)
            DSIZE_BYTE: extended = unsigned_load
                ? {{(`MS_XLEN-8){1'b0}}, lane_byte}
                : {{(`MS_XLEN-8){lane_byte[7]}}, lane_byte};
            DSIZE_HALF: extended = unsigned_load
                ? {{(`MS_XLEN-16){1'b0}}, lane_half}
                : {{(`MS_XLEN-16){lane_half[15]}}, lane_half};
            default:    extended = rword.word;
        endcase
    end

    // nothing valid outside an access or after a timeout
    assign load_value = (ctrl.fault || !ctrl.active) ? '0 : extended;

endmodule

`default_nettype wire

// File: src/mem_bus_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bus_fsm import mem_stage_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           keep,
    input  memrw_e         memrw,
    input  logic           dbusy,
    input  logic           dready_n,
    input  logic           wait_expired,
    output logic           dreq,
    output logic           dwrite,
    output logic           wait_count_en,
    output logic           wait_clear,
    mem_ctrl_if.fsm        ctrl
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_e;

    state_e state;
    state_e next_state;
    logic   is_load;
    logic   done;

    assign is_load = (memrw == MEMRW_LOAD);
    assign dreq    = (memrw != MEMRW_NONE) && !keep;
    assign dwrite  = dreq && memrw[0];
    assign done    = dreq && !dbusy && !dready_n; // bus finished this cycle

    always_comb begin
        next_state   = state;
        ctrl.stall   = 1'b0;
        ctrl.capture = 1'b0;
        ctrl.fault   = 1'b0;
        wait_clear   = 1'b0;
        case (state)
            ST_IDLE: begin
                if (done) begin
                    ctrl.capture = is_load;
                end else if (dreq) begin
                    ctrl.stall = 1'b1;
                    next_state = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (memrw == MEMRW_NONE) begin
                    next_state = ST_IDLE; // request withdrawn
                    wait_clear = 1'b1;
                end else if (done) begin
                    ctrl.capture = is_load;
                    next_state   = ST_IDLE;
                    wait_clear   = 1'b1;
                end else if (wait_expired) begin
                    ctrl.fault = 1'b1;
                    next_state = ST_IDLE;
                    wait_clear = 1'b1;
                end else begin
                    ctrl.stall = dreq; // keep pauses the wait
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    assign wait_count_en = ctrl.stall;
    assign ctrl.active   = dreq || (state == ST_WAIT);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // upstream holds or withdraws its operation during a stall
    a_op_held_in_stall: assert property (
        @(posedge clk) disable iff (!rst)
        ctrl.stall |=> (memrw == $past(memrw) || memrw == MEMRW_NONE)
    );

endmodule

`default_nettype wire

// File: src/bus_wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module bus_wait_timer (
    input  logic clk,
    input  logic rst,
    input  logic count_en,
    input  logic clear,
    output logic expired
);

    localparam logic [`MS_WAIT_W-1:0] LIMIT = `MS_WAIT_W'(`MS_WAIT_LIMIT);

    logic [`MS_WAIT_W-1:0] count;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count_en && count != LIMIT) begin
            count <= count + `MS_WAIT_W'(1); // saturates at the limit
        end
    end

    assign expired = (count == LIMIT);

    // no counting once the limit is reached
    a_no_count_at_limit: assert property (
        @(posedge clk) disable iff (!rst)
        expired |-> !count_en
    );

endmodule

`default_nettype wire

// File: src/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module branch_resolve import mem_stage_pkg::*; (
    input  memb_e               memb,
    input  logic [`MS_XLEN-1:0] alu_result,
    input  logic [`MS_XLEN-1:0] pc_branch,
    output logic                taken,
    output logic [`MS_XLEN-1:0] target
);

    always_comb begin
        case (memb)
            MEMB_BEQ:  taken = (alu_result == '0);
            MEMB_BNE:  taken = (alu_result != '0);
            MEMB_BGE:  taken = ~alu_result[0]; // slt flag clear
            MEMB_BLT:  taken = alu_result[0];
            MEMB_JAL,
            MEMB_JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // jalr target already computed by the alu
    assign target = (memb == MEMB_JALR) ? alu_result : pc_branch;

endmodule

`default_nettype wire

// File: src/mem_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_ctrl_if;

    logic stall;   // access not finished yet
    logic capture; // rdata valid this cycle
    logic fault;   // wait limit hit
    logic active;

    modport fsm (
        output stall,
        output capture,
        output fault,
        output active
    );

    modport dp (
        input stall,
        input capture,
        input fault,
        input active
    );

endinterface

`default_nettype wire

// File: src/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    `include "mem_stage_cfg.svh"

    typedef enum logic [2:0] {
        MEMB_NONE = 3'd0,
        MEMB_BEQ  = 3'd1,
        MEMB_BNE  = 3'd2,
        MEMB_BGE  = 3'd3, // alu gives slt flag
        MEMB_BLT  = 3'd4,
        MEMB_JAL  = 3'd5,
        MEMB_JALR = 3'd6
    } memb_e;

    // bit 0 store, bit 1 load
    typedef enum logic [1:0] {
        MEMRW_NONE  = 2'b00,
        MEMRW_STORE = 2'b01,
        MEMRW_LOAD  = 2'b10
    } memrw_e;

    typedef enum logic [1:0] {
        DSIZE_BYTE = 2'd0,
        DSIZE_HALF = 2'd1,
        DSIZE_WORD = 2'd2
    } dsize_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    // read word, whole or per byte lane
    typedef union packed {
        logic [`MS_XLEN-1:0]              word;
        logic [`MS_XLEN/8-1:0][7:0]       lanes;
    } load_word_u;

endpackage

`default_nettype wire

// File: src/mem_stage_cfg.svh
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// datapath and address width
`define MS_XLEN 32

`define MS_REG_AW 5

// bus wait cycles before the access is dropped
`define MS_WAIT_LIMIT 16
`define MS_WAIT_W 5 // must hold MS_WAIT_LIMIT

`endif
